// File: rtl/rv_decode_defs.svh
`ifndef RV_DECODE_DEFS_SVH
`define RV_DECODE_DEFS_SVH

// Datapath and register file
`define RV_XLEN 32
`define RV_REG_W 5

// Exception causes, mcause numbering
`define RV_ECAUSE_W 4
`define RV_CAUSE_ILLEGAL (`RV_ECAUSE_W'(2))
`define RV_CAUSE_BREAK (`RV_ECAUSE_W'(3))
`define RV_CAUSE_ECALL (`RV_ECAUSE_W'(11))

`endif

// File: rtl/rv_decode_pkg.sv
`include "rv_decode_defs.svh"

package rv_decode_pkg;

    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_FENCE  = 7'b0001111,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    // Same order as funct3 so OP and OP-IMM map directly
    typedef enum logic [2:0] {
        ALU_ADD_SUB = 3'd0,
        ALU_SLL     = 3'd1,
        ALU_SLT     = 3'd2,
        ALU_SLTU    = 3'd3,
        ALU_XOR     = 3'd4,
        ALU_SR      = 3'd5,
        ALU_OR      = 3'd6,
        ALU_AND     = 3'd7
    } alu_op_e;

    typedef enum logic [1:0] {
        SEL_REG  = 2'd0,
        SEL_IMM  = 2'd1,
        SEL_PC   = 2'd2,
        SEL_ZERO = 2'd3
    } alu_sel_e;

    typedef enum logic [1:0] {
        WB_ALU     = 2'd0,
        WB_LOAD    = 2'd1,
        WB_NEXT_PC = 2'd2
    } write_sel_e;

    typedef enum logic [2:0] {
        IMM_NONE = 3'd0,
        IMM_I    = 3'd1,
        IMM_S    = 3'd2,
        IMM_B    = 3'd3,
        IMM_U    = 3'd4,
        IMM_J    = 3'd5
    } imm_fmt_e;

    typedef struct packed {
        alu_op_e                 alu_op;
        logic                    alu_alt;     // SUB or SRA
        alu_sel_e                alu_a_sel;
        alu_sel_e                alu_b_sel;
        logic                    cmp_less;
        logic                    cmp_sign;
        logic                    cmp_negate;
        logic                    jump;
        logic                    branch;
        logic                    load;
        logic                    store;
        logic [1:0]              ls_size;     // Byte, half, word
        logic                    load_signed;
        write_sel_e              write_sel;
        logic [`RV_REG_W-1:0]    rd_addr;
        logic                    exception;
        logic [`RV_ECAUSE_W-1:0] ecause;
    } ctrl_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0] pc;
        logic [`RV_XLEN-1:0] next_pc;
        logic [`RV_XLEN-1:0] rs1_data;
        logic [`RV_XLEN-1:0] rs2_data;
        logic [`RV_XLEN-1:0] imm;
        ctrl_t               ctrl;
    } ex_bundle_t;

endpackage

// File: rtl/imm_gen.sv
`include "rv_decode_defs.svh"

module imm_gen import rv_decode_pkg::*; (
    input  logic [`RV_XLEN-1:0] instr,
    input  imm_fmt_e            imm_fmt,
    output logic [`RV_XLEN-1:0] imm
);

    logic sign;

    assign sign = instr[31];

    always_comb begin
        case (imm_fmt)
            IMM_I: begin
                imm = {{20{sign}}, instr[31:20]};
            end
            IMM_S: begin
                imm = {{20{sign}}, instr[31:25], instr[11:7]};
            end
            IMM_B: begin
                imm = {{19{sign}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            IMM_U: begin
                imm = {instr[31:12], 12'b0};
            end
            IMM_J: begin
                imm = {{11{sign}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: begin
                imm = '0; // No immediate
            end
        endcase
    end

endmodule

// File: rtl/ctrl_decode.sv
`include "rv_decode_defs.svh"

module ctrl_decode import rv_decode_pkg::*; (
    input  logic [`RV_XLEN-1:0] instr,
    output ctrl_t               ctrl,
    output imm_fmt_e            imm_fmt
);

    opcode_e              opcode;
    logic [2:0]           funct3;
    logic [6:0]           funct7;
    logic [`RV_REG_W-1:0] rd;
    logic [`RV_REG_W-1:0] rs1;
    logic [`RV_REG_W-1:0] rs2;
    logic                 sys_plain;
    logic                 illegal;

    assign opcode = opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rd     = instr[11:7];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    // ECALL and EBREAK differ only in the rs2 field
    assign sys_plain = (funct3 == 3'b000) && (rs1 == '0) && (rd == '0) && (funct7 == 7'd0);

    always_comb begin
        ctrl    = '0;
        imm_fmt = IMM_NONE;
        illegal = 1'b0;

        case (opcode)
            OPC_LUI: begin
                ctrl.alu_op    = ALU_OR;
                ctrl.alu_a_sel = SEL_ZERO;
                ctrl.alu_b_sel = SEL_IMM;
                ctrl.rd_addr   = rd;
                imm_fmt        = IMM_U;
            end
            OPC_AUIPC: begin
                ctrl.alu_op    = ALU_ADD_SUB;
                ctrl.alu_a_sel = SEL_PC;
                ctrl.alu_b_sel = SEL_IMM;
                ctrl.rd_addr   = rd;
                imm_fmt        = IMM_U;
            end
            OPC_JAL: begin
                ctrl.alu_op    = ALU_ADD_SUB;
                ctrl.alu_a_sel = SEL_PC;
                ctrl.alu_b_sel = SEL_IMM;
                ctrl.branch    = 1'b1;
                ctrl.jump      = 1'b1;
                ctrl.write_sel = WB_NEXT_PC;
                ctrl.rd_addr   = rd;
                imm_fmt        = IMM_J;
            end
            OPC_JALR: begin
                ctrl.alu_op    = ALU_ADD_SUB;
                ctrl.alu_a_sel = SEL_REG; // Target is rs1 + imm
                ctrl.alu_b_sel = SEL_IMM;
                ctrl.branch    = 1'b1;
                ctrl.jump      = 1'b1;
                ctrl.write_sel = WB_NEXT_PC;
                ctrl.rd_addr   = rd;
                imm_fmt        = IMM_I;
                illegal        = (funct3 != 3'b000);
            end
            OPC_BRANCH: begin
                ctrl.alu_op     = ALU_ADD_SUB;
                ctrl.alu_a_sel  = SEL_PC;
                ctrl.alu_b_sel  = SEL_IMM;
                ctrl.branch     = 1'b1;
                ctrl.cmp_less   = funct3[2];
                ctrl.cmp_sign   = funct3[1];
                ctrl.cmp_negate = funct3[0];
                imm_fmt         = IMM_B;
                illegal         = (funct3[2:1] == 2'b01);
            end
            OPC_LOAD: begin
                ctrl.alu_op      = ALU_ADD_SUB;
                ctrl.alu_a_sel   = SEL_REG;
                ctrl.alu_b_sel   = SEL_IMM;
                ctrl.load        = 1'b1;
                ctrl.write_sel   = WB_LOAD;
                ctrl.ls_size     = funct3[1:0];
                ctrl.load_signed = ~funct3[2]; // LBU and LHU are zero extended
                ctrl.rd_addr     = rd;
                imm_fmt          = IMM_I;
                illegal          = (funct3[1:0] == 2'b11) || (funct3 == 3'b110);
            end
            OPC_STORE: begin
                ctrl.store = 1'b1;
                imm_fmt    = IMM_S;
                illegal    = funct3[2] || (funct3[1:0] == 2'b11);
            end
            OPC_OP_IMM: begin
                ctrl.alu_op    = alu_op_e'(funct3);
                ctrl.alu_alt   = (funct3 == 3'b101) && instr[30]; // SRAI
                ctrl.alu_a_sel = SEL_REG;
                ctrl.alu_b_sel = SEL_IMM;
                ctrl.rd_addr   = rd;
                imm_fmt        = IMM_I;
            end
            OPC_OP: begin
                ctrl.alu_op    = alu_op_e'(funct3);
                ctrl.alu_alt   = instr[30];
                ctrl.alu_a_sel = SEL_REG;
                ctrl.alu_b_sel = SEL_REG;
                ctrl.rd_addr   = rd;
                illegal = !((funct7 == 7'b0000000) ||
                            (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)));
            end
            OPC_FENCE: begin
                illegal = (funct3 != 3'b000); // Otherwise a no-op
            end
            OPC_SYSTEM: begin
                if (sys_plain && rs2 == 5'd0) begin
                    ctrl.exception = 1'b1;
                    ctrl.ecause    = `RV_CAUSE_ECALL;
                end else if (sys_plain && rs2 == 5'd1) begin
                    ctrl.exception = 1'b1;
                    ctrl.ecause    = `RV_CAUSE_BREAK;
                end else begin
                    illegal = 1'b1; // CSR ops, MRET, WFI included
                end
            end
            default: begin
                illegal = 1'b1;
            end
        endcase

        // An illegal instruction must not reach memory or writeback
        if (illegal) begin
            ctrl           = '0;
            ctrl.exception = 1'b1;
            ctrl.ecause    = `RV_CAUSE_ILLEGAL;
        end
    end

endmodule

// File: rtl/hazard_check.sv
`include "rv_decode_defs.svh"

module hazard_check (
    input  logic [`RV_REG_W-1:0] rs1_addr,
    input  logic [`RV_REG_W-1:0] rs2_addr,
    input  logic [`RV_REG_W-1:0] hazard_rd_0,
    input  logic [`RV_REG_W-1:0] hazard_rd_1,
    output logic                 stall
);

    logic hit_0;
    logic hit_1;

    // x0 never carries a dependency
    assign hit_0 = (hazard_rd_0 != '0) &&
                   ((hazard_rd_0 == rs1_addr) || (hazard_rd_0 == rs2_addr));
    assign hit_1 = (hazard_rd_1 != '0) &&
                   ((hazard_rd_1 == rs1_addr) || (hazard_rd_1 == rs2_addr));

    assign stall = hit_0 || hit_1;

endmodule

// File: rtl/decode_stage.sv
`include "rv_decode_defs.svh"

module decode_stage import rv_decode_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [`RV_XLEN-1:0]  pc_in,
    input  logic [`RV_XLEN-1:0]  next_pc_in,
    input  logic [`RV_XLEN-1:0]  instr,
    input  logic                 valid_in,
    input  logic                 stall_in,
    input  logic                 invalidate,
    input  logic [`RV_REG_W-1:0] hazard_rd_0,
    input  logic [`RV_REG_W-1:0] hazard_rd_1,
    input  logic [`RV_XLEN-1:0]  rs1_data,
    input  logic [`RV_XLEN-1:0]  rs2_data,
    output logic [`RV_REG_W-1:0] rs1_select,
    output logic [`RV_REG_W-1:0] rs2_select,
    output logic                 stall_out,
    output ex_bundle_t           ex_out,
    output logic                 valid_out
);

    ctrl_t               dec_ctrl;
    imm_fmt_e            imm_fmt;
    logic [`RV_XLEN-1:0] imm;
    ex_bundle_t          ex_next;

    // Register file is read in this cycle
    assign rs1_select = instr[19:15];
    assign rs2_select = instr[24:20];

    ctrl_decode u_ctrl (
        .instr   (instr),
        .ctrl    (dec_ctrl),
        .imm_fmt (imm_fmt)
    );

    imm_gen u_imm (
        .instr   (instr),
        .imm_fmt (imm_fmt),
        .imm     (imm)
    );

    hazard_check u_hazard (
        .rs1_addr    (rs1_select),
        .rs2_addr    (rs2_select),
        .hazard_rd_0 (hazard_rd_0),
        .hazard_rd_1 (hazard_rd_1),
        .stall       (stall_out)
    );

    assign ex_next = '{
        pc:       pc_in,
        next_pc:  next_pc_in,
        rs1_data: rs1_data,
        rs2_data: rs2_data,
        imm:      imm,
        ctrl:     dec_ctrl
    };

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_out             <= 1'b0;
            ex_out.ctrl.exception <= 1'b0;
        end else if (!stall_in) begin
            if (stall_out || invalidate) begin
                valid_out <= 1'b0; // Bubble, payload holds
            end else begin
                ex_out    <= ex_next;
                valid_out <= valid_in;
            end
        end
    end

    // Back-pressure from execute freezes the whole register
    property p_hold_on_stall;
        @(posedge clk) disable iff (!rst_n)
            stall_in |=> ($stable(ex_out) && $stable(valid_out));
    endproperty
    a_hold_on_stall: assert property (p_hold_on_stall)
        else $error("output changed under stall_in");

    property p_flush;
        @(posedge clk) disable iff (!rst_n)
            (invalidate && !stall_in) |=> !valid_out;
    endproperty
    a_flush: assert property (p_flush)
        else $error("valid_out set after invalidate");

endmodule

// File: bench/tb_decode_stage.sv
`include "rv_decode_defs.svh"

module tb_decode_stage import rv_decode_pkg::*; ();

    localparam int N_ALU        = 40;
    localparam int N_FLOW       = 40;
    localparam int N_TRAPS      = 19;
    localparam int N_HAZ        = 8;
    localparam int STALL_CYCLES = 5;
    localparam int TEST_CYCLES  = 10 + 2 * (N_ALU + N_FLOW + N_TRAPS + N_HAZ) + STALL_CYCLES + 6;
    localparam int MARGIN       = 100;

    logic                 clk;
    logic                 rst_n;
    logic [`RV_XLEN-1:0]  pc_in;
    logic [`RV_XLEN-1:0]  next_pc_in;
    logic [`RV_XLEN-1:0]  instr;
    logic                 valid_in;
    logic                 stall_in;
    logic                 invalidate;
    logic [`RV_REG_W-1:0] hazard_rd_0;
    logic [`RV_REG_W-1:0] hazard_rd_1;
    logic [`RV_XLEN-1:0]  rs1_data;
    logic [`RV_XLEN-1:0]  rs2_data;
    logic [`RV_REG_W-1:0] rs1_select;
    logic [`RV_REG_W-1:0] rs2_select;
    logic                 stall_out;
    ex_bundle_t           ex_out;
    logic                 valid_out;

    integer     seed;
    int         errors;
    int         checks;
    ex_bundle_t last_exp; // Bundle captured by the latest accepted instruction

    decode_stage u_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .pc_in       (pc_in),
        .next_pc_in  (next_pc_in),
        .instr       (instr),
        .valid_in    (valid_in),
        .stall_in    (stall_in),
        .invalidate  (invalidate),
        .hazard_rd_0 (hazard_rd_0),
        .hazard_rd_1 (hazard_rd_1),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .rs1_select  (rs1_select),
        .rs2_select  (rs2_select),
        .stall_out   (stall_out),
        .ex_out      (ex_out),
        .valid_out   (valid_out)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [`RV_XLEN-1:0] reg_value(input logic [`RV_REG_W-1:0] idx);
        return {{(`RV_XLEN - `RV_REG_W){1'b0}}, idx} * 32'h01010101;
    endfunction

    // Register file model, read in the same cycle
    assign rs1_data = reg_value(rs1_select);
    assign rs2_data = reg_value(rs2_select);

    function automatic logic [31:0] imm_value(input imm_fmt_e fmt, input logic [31:0] ins);
        logic [12:0] b_imm;
        logic [20:0] j_imm;
        b_imm = {ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        j_imm = {ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        case (fmt)
            IMM_I:   return {{20{ins[31]}}, ins[31:20]};
            IMM_S:   return {{20{ins[31]}}, ins[31:25], ins[11:7]};
            IMM_B:   return {{19{b_imm[12]}}, b_imm};
            IMM_U:   return {ins[31:12], 12'h000};
            IMM_J:   return {{11{j_imm[20]}}, j_imm};
            default: return 32'h0;
        endcase
    endfunction

    function automatic ex_bundle_t expect_bundle(input logic [31:0] pc, input logic [31:0] npc,
                                                 input logic [31:0] ins);
        ex_bundle_t b;
        ctrl_t      c;
        imm_fmt_e   fmt;
        logic       bad;
        logic [2:0] f3;
        logic [6:0] f7;
        logic [4:0] rd;
        f3  = ins[14:12];
        f7  = ins[31:25];
        rd  = ins[11:7];
        c   = '0; // ADD and REG are the zero values
        fmt = IMM_NONE;
        bad = 1'b0;
        case (ins[6:0])
            OPC_LUI: begin
                c.alu_op    = ALU_OR;
                c.alu_a_sel = SEL_ZERO;
                c.alu_b_sel = SEL_IMM;
                c.rd_addr   = rd;
                fmt         = IMM_U;
            end
            OPC_AUIPC: begin
                c.alu_a_sel = SEL_PC;
                c.alu_b_sel = SEL_IMM;
                c.rd_addr   = rd;
                fmt         = IMM_U;
            end
            OPC_JAL, OPC_JALR: begin
                c.alu_a_sel = (ins[6:0] == OPC_JAL) ? SEL_PC : SEL_REG;
                c.alu_b_sel = SEL_IMM;
                c.jump      = 1'b1;
                c.branch    = 1'b1;
                c.write_sel = WB_NEXT_PC;
                c.rd_addr   = rd;
                fmt         = (ins[6:0] == OPC_JAL) ? IMM_J : IMM_I;
                bad         = (ins[6:0] == OPC_JALR) && (f3 != 3'b000);
            end
            OPC_BRANCH: begin
                c.alu_a_sel  = SEL_PC;
                c.alu_b_sel  = SEL_IMM;
                c.branch     = 1'b1;
                c.cmp_less   = f3[2];
                c.cmp_sign   = f3[1];
                c.cmp_negate = f3[0];
                fmt          = IMM_B;
                bad          = (f3 == 3'b010) || (f3 == 3'b011);
            end
            OPC_LOAD: begin
                c.alu_b_sel   = SEL_IMM;
                c.load        = 1'b1;
                c.write_sel   = WB_LOAD;
                c.ls_size     = f3[1:0];
                c.load_signed = !f3[2];
                c.rd_addr     = rd;
                fmt           = IMM_I;
                bad           = (f3 == 3'b011) || (f3 == 3'b110) || (f3 == 3'b111);
            end
            OPC_STORE: begin
                c.store = 1'b1;
                fmt     = IMM_S;
                bad     = f3[2] || (f3 == 3'b011);
            end
            OPC_OP_IMM: begin
                c.alu_op    = alu_op_e'(f3);
                c.alu_alt   = (f3 == 3'b101) && ins[30];
                c.alu_b_sel = SEL_IMM;
                c.rd_addr   = rd;
                fmt         = IMM_I;
            end
            OPC_OP: begin
                c.alu_op  = alu_op_e'(f3);
                c.alu_alt = ins[30];
                c.rd_addr = rd;
                bad = !((f7 == 7'h00) || ((f7 == 7'h20) && (f3 == 3'b000 || f3 == 3'b101)));
            end
            OPC_FENCE: begin
                bad = (f3 != 3'b000);
            end
            OPC_SYSTEM: begin
                if (ins[31:7] == 25'h0000000) begin
                    c.exception = 1'b1;
                    c.ecause    = `RV_CAUSE_ECALL;
                end else if (ins[31:7] == 25'h0002000) begin // rs2 field is 1
                    c.exception = 1'b1;
                    c.ecause    = `RV_CAUSE_BREAK;
                end else begin
                    bad = 1'b1;
                end
            end
            default: begin
                bad = 1'b1;
            end
        endcase
        if (bad) begin
            c           = '0;
            c.exception = 1'b1;
            c.ecause    = `RV_CAUSE_ILLEGAL;
        end
        b.pc       = pc;
        b.next_pc  = npc;
        b.rs1_data = reg_value(ins[19:15]);
        b.rs2_data = reg_value(ins[24:20]);
        b.imm      = imm_value(fmt, ins);
        b.ctrl     = c;
        return b;
    endfunction

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR time %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_bundle(input ex_bundle_t exp);
        check("ex_out.pc", 64'(ex_out.pc), 64'(exp.pc));
        check("ex_out.next_pc", 64'(ex_out.next_pc), 64'(exp.next_pc));
        check("ex_out.rs1_data", 64'(ex_out.rs1_data), 64'(exp.rs1_data));
        check("ex_out.rs2_data", 64'(ex_out.rs2_data), 64'(exp.rs2_data));
        check("ex_out.imm", 64'(ex_out.imm), 64'(exp.imm));
        check("ex_out.ctrl", 64'(ex_out.ctrl), 64'(exp.ctrl));
    endtask

    // Present one instruction, expect no stall, check the registered result
    task automatic run_one(input logic [31:0] ins, input logic vin,
                           input logic [4:0] h0, input logic [4:0] h1);
        logic [31:0] pc;
        ex_bundle_t  exp;
        pc      = $random(seed);
        pc[1:0] = 2'b00;
        exp     = expect_bundle(pc, pc + 32'd4, ins);
        @(posedge clk);
        pc_in       <= pc;
        next_pc_in  <= pc + 32'd4;
        instr       <= ins;
        valid_in    <= vin;
        stall_in    <= 1'b0;
        invalidate  <= 1'b0;
        hazard_rd_0 <= h0;
        hazard_rd_1 <= h1;
        @(negedge clk);
        check("stall_out", 64'(stall_out), 64'(0));
        check("rs1_select", 64'(rs1_select), 64'(ins[19:15]));
        check("rs2_select", 64'(rs2_select), 64'(ins[24:20]));
        @(posedge clk);
        @(negedge clk);
        compare_bundle(exp);
        check("valid_out", 64'(valid_out), 64'(vin));
        last_exp = exp;
    endtask

    task automatic stall_case(input logic [31:0] ins, input logic [4:0] h0, input logic [4:0] h1);
        @(posedge clk);
        instr       <= ins;
        pc_in       <= pc_in + 32'h40;
        valid_in    <= 1'b1;
        hazard_rd_0 <= h0;
        hazard_rd_1 <= h1;
        @(negedge clk);
        check("stall_out", 64'(stall_out), 64'(1));
        @(posedge clk);
        @(negedge clk);
        check("valid_out", 64'(valid_out), 64'(0));
        compare_bundle(last_exp); // Bubble keeps the payload
    endtask

    task automatic expect_trap(input logic [31:0] ins, input logic [3:0] cause);
        run_one(ins, 1'b1, 5'd0, 5'd0);
        check("ex_out.ctrl.exception", 64'(ex_out.ctrl.exception), 64'(1));
        check("ex_out.ctrl.ecause", 64'(ex_out.ctrl.ecause), 64'(cause));
    endtask

    task automatic test_reset_state();
        @(negedge clk);
        check("valid_out", 64'(valid_out), 64'(0));
        check("ex_out.ctrl.exception", 64'(ex_out.ctrl.exception), 64'(0));
        @(posedge clk);
        @(negedge clk);
        check("valid_out", 64'(valid_out), 64'(0));
        check("ex_out.ctrl.exception", 64'(ex_out.ctrl.exception), 64'(0));
    endtask

    task automatic test_alu_group();
        logic [31:0] ins;
        logic [31:0] r;
        logic [2:0]  f3;
        repeat (N_ALU) begin
            ins = $random(seed);
            r   = $random(seed);
            f3  = ins[14:12];
            case (r[3:2])
                2'd0: ins[6:0] = OPC_LUI;
                2'd1: ins[6:0] = OPC_AUIPC;
                2'd2: begin
                    ins[6:0]   = OPC_OP;
                    ins[31:25] = ((f3 == 3'b000 || f3 == 3'b101) && ins[30]) ? 7'h20 : 7'h00;
                end
                default: ins[6:0] = OPC_OP_IMM;
            endcase
            run_one(ins, r[0], 5'd0, 5'd0);
        end
    endtask

    task automatic test_flow_group();
        logic [31:0] ins;
        logic [2:0]  f3;
        int          kind;
        int          idx;
        repeat (N_FLOW) begin
            ins  = $random(seed);
            kind = {$random(seed)} % 5;
            idx  = {$random(seed)} % 5;
            f3   = ins[14:12];
            case (kind)
                0: ins[6:0] = OPC_JAL;
                1: begin
                    ins[6:0]   = OPC_JALR;
                    ins[14:12] = 3'b000;
                end
                2: begin
                    ins[6:0] = OPC_BRANCH;
                    if (f3[2:1] == 2'b01) begin
                        f3[2] = 1'b1; // Skip the two reserved codes
                    end
                    ins[14:12] = f3;
                end
                3: begin
                    ins[6:0]   = OPC_LOAD;
                    ins[14:12] = (idx < 3) ? 3'(idx) : 3'(idx + 1); // LB LH LW LBU LHU
                end
                default: begin
                    ins[6:0]   = OPC_STORE;
                    ins[14:12] = 3'(idx % 3);
                end
            endcase
            run_one(ins, 1'b1, 5'd0, 5'd0);
        end
    endtask

    task automatic test_traps();
        expect_trap(32'h000010e7, `RV_CAUSE_ILLEGAL); // JALR funct3 1
        expect_trap(32'h00002063, `RV_CAUSE_ILLEGAL);
        expect_trap(32'h00003063, `RV_CAUSE_ILLEGAL);
        expect_trap(32'h00003283, `RV_CAUSE_ILLEGAL);
        expect_trap(32'h00006283, `RV_CAUSE_ILLEGAL);
        expect_trap(32'h00007283, `RV_CAUSE_ILLEGAL);
        expect_trap(32'h00003023, `RV_CAUSE_ILLEGAL);
        expect_trap(32'h00004023, `RV_CAUSE_ILLEGAL);
        expect_trap(32'h023100b3, `RV_CAUSE_ILLEGAL); // MUL
        expect_trap(32'h400010b3, `RV_CAUSE_ILLEGAL);
        expect_trap(32'h0000100f, `RV_CAUSE_ILLEGAL); // FENCE.I
        expect_trap(32'h0000007f, `RV_CAUSE_ILLEGAL);
        expect_trap(32'h00000000, `RV_CAUSE_ILLEGAL);
        expect_trap(32'h30009073, `RV_CAUSE_ILLEGAL); // CSRRW
        expect_trap(32'h342022f3, `RV_CAUSE_ILLEGAL);
        expect_trap(32'h30200073, `RV_CAUSE_ILLEGAL); // MRET
        expect_trap(32'h10500073, `RV_CAUSE_ILLEGAL); // WFI
        expect_trap(32'h00000073, `RV_CAUSE_ECALL);
        expect_trap(32'h00100073, `RV_CAUSE_BREAK);
    endtask

    task automatic test_hazards();
        logic [31:0] ins;
        logic [31:0] ins_x0;
        ins    = {7'h00, 5'd9, 5'd7, 3'b000, 5'd3, OPC_OP}; // add x3, x7, x9
        ins_x0 = {7'h00, 5'd0, 5'd0, 3'b000, 5'd4, OPC_OP};
        run_one(ins, 1'b1, 5'd0, 5'd0);
        stall_case(ins, 5'd7, 5'd0);
        stall_case(ins, 5'd0, 5'd9);
        stall_case(ins, 5'd9, 5'd0);
        stall_case(ins, 5'd0, 5'd7);
        run_one(ins, 1'b1, 5'd12, 5'd20);
        run_one(ins_x0, 1'b1, 5'd0, 5'd0);
    endtask

    task automatic test_stall_hold();
        logic [31:0] ins_a;
        logic [31:0] ins_b;
        ins_a      = $random(seed);
        ins_a[6:0] = OPC_OP_IMM;
        ins_b      = $random(seed);
        ins_b[6:0] = OPC_LUI;
        run_one(ins_a, 1'b1, 5'd0, 5'd0);
        @(posedge clk);
        stall_in <= 1'b1;
        instr    <= ins_b;
        pc_in    <= pc_in + 32'h100;
        repeat (STALL_CYCLES) begin
            @(posedge clk);
            @(negedge clk);
            compare_bundle(last_exp);
            check("valid_out", 64'(valid_out), 64'(1));
        end
        @(posedge clk);
        stall_in   <= 1'b0;
        invalidate <= 1'b1;
        @(posedge clk);
        @(negedge clk);
        check("valid_out", 64'(valid_out), 64'(0));
        compare_bundle(last_exp);
        run_one(ins_b, 1'b1, 5'd0, 5'd0); // Pipeline resumes
    endtask

    initial begin
        seed        = 20193;
        errors      = 0;
        checks      = 0;
        rst_n       = 1'b0;
        pc_in       = '0;
        next_pc_in  = '0;
        instr       = 32'h00000013; // NOP
        valid_in    = 1'b0;
        stall_in    = 1'b0;
        invalidate  = 1'b0;
        hazard_rd_0 = '0;
        hazard_rd_1 = '0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        test_reset_state();
        test_alu_group();
        test_flow_group();
        test_traps();
        test_hazards();
        test_stall_hold();

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        #((TEST_CYCLES + MARGIN) * 100);
        $display("Watchdog expired: tests did not finish within %0d cycles",
                 TEST_CYCLES + MARGIN);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// File: rv_decode.f
+incdir+rtl
rtl/rv_decode_pkg.sv
rtl/imm_gen.sv
rtl/ctrl_decode.sv
rtl/hazard_check.sv
rtl/decode_stage.sv
bench/tb_decode_stage.sv

// File: run_sim.sh
#!/bin/sh
# Build the decode stage testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
    --top-module tb_decode_stage \
    -f rv_decode.f \
    -o tb_decode_stage

./obj_dir/tb_decode_stage | tee "$LOG"

if grep -qx "Simulation finished: PASS" "$LOG"; then
    echo "run_sim: passed"
else
    echo "run_sim: failed, see $LOG"
    exit 1
fi
